// File: common/afe_pkg.sv
////////////////////////////////////////
// Widths, register map and APB slave
// state encoding for the analog front end
// Imported by the RTL blocks that use it
////////////////////////////////////////

package afe_pkg;

  ////////////////////////////////////////
  // Sample path
  ////////////////////////////////////////

  localparam int ADC_W        = 16;  // Raw ADC word, two reserved LSBs
  localparam int DAT_W_DEF    = 14;  // Default sample width
  localparam int AVG_LOG2_DEF = 6;   // 64 sample window on channel A

  ////////////////////////////////////////
  // APB and register map
  ////////////////////////////////////////

  localparam int APB_AW = 8;
  localparam int APB_DW = 32;

  // Register addresses
  localparam logic [APB_AW-1:0] REG_ID_ADDR   = 8'h00;  // Read only ID word
  localparam logic [APB_AW-1:0] REG_CTRL_ADDR = 8'h04;  // Loopback and averaging

  // Control register fields
  localparam int CTRL_LOOP_BIT = 0;  // Digital loopback
  localparam int CTRL_AVG_BIT  = 1;  // Channel A moving average

  // Identification, ASCII "AF" plus revision
  localparam logic [APB_DW-1:0] AFE_ID = 32'h4146_0001;

  // APB slave phase tracking
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,  // No transfer
    ST_SETUP  = 2'd1,  // Setup cycle seen
    ST_ACCESS = 2'd2   // Transfer just completed
  } apb_state_e;

endpackage : afe_pkg

// File: common/apb_if.sv
////////////////////////////////////////
// APB bus between the top level and the
// register block, one slave, no wait
////////////////////////////////////////

`timescale 1ns/1ps

interface apb_if;
  import afe_pkg::*;

  logic              psel;     // Slave select
  logic              penable;  // Access phase
  logic              pwrite;   // 1 write, 0 read
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;   // Transfer done
  logic              pslverr;  // Unmapped address

  // Requester side
  modport master (
    output psel, penable, pwrite, paddr, pwdata,
    input  prdata, pready, pslverr
  );

  // Completer side
  modport slave (
    input  psel, penable, pwrite, paddr, pwdata,
    output prdata, pready, pslverr
  );

endinterface : apb_if

// File: dac/avg_window_ptr.sv
////////////////////////////////////////
// Write pointer for the averaging window
// Advances every clock, wraps at depth
////////////////////////////////////////

`timescale 1ns/1ps

module avg_window_ptr #(
  parameter int AVG_LOG2 = afe_pkg::AVG_LOG2_DEF
) (
  input  logic                adc_clk,
  input  logic                adc_rstn,
  output logic [AVG_LOG2-1:0] ptr_o    // Slot written this cycle
);

  localparam logic [AVG_LOG2-1:0] LAST = '1;  // Last window slot

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      ptr_o <= '0;
    end else begin
      ptr_o <= ptr_o + 1'b1;         // Power of two depth wraps by itself
    end
  end

  // Back to slot 0 right after the last one
  a_ptr_wrap: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    (ptr_o == LAST) |=> (ptr_o == '0));

endmodule : avg_window_ptr

// File: dac/dac_avg.sv
////////////////////////////////////////
// Channel A moving average over 2**AVG_LOG2
// formatted codes, output inverted
// Bypass gives a plain 1 cycle register
////////////////////////////////////////

`timescale 1ns/1ps

module dac_avg #(
  parameter int DAT_W    = afe_pkg::DAT_W_DEF,
  parameter int AVG_LOG2 = afe_pkg::AVG_LOG2_DEF
) (
  input  logic             adc_clk,
  input  logic             adc_rstn,
  input  logic             avg_en_i,  // Select average or plain code
  input  logic [DAT_W-1:0] code_a_i,  // Formatted CH A
  output logic [DAT_W-1:0] dac_a_o
);

  localparam int DEPTH = 2**AVG_LOG2;
  localparam int SUM_W = DAT_W + AVG_LOG2;  // Full window sum

  logic [AVG_LOG2-1:0] ptr;             // Oldest slot, overwritten now
  logic [DAT_W-1:0]    win_q [DEPTH];   // Window buffer
  logic [SUM_W-1:0]    sum_q;           // Running window sum

  avg_window_ptr #(.AVG_LOG2(AVG_LOG2)) u_avg_window_ptr (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .ptr_o    (ptr)
  );

  ////////////////////////////////////////
  // Window and running sum
  ////////////////////////////////////////

  // Runs whether averaging is selected or not
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      for (int i = 0; i < DEPTH; i++) begin
        win_q[i] <= '0;
      end
      sum_q <= '0;
    end else begin
      win_q[ptr] <= code_a_i;
      sum_q      <= sum_q + SUM_W'(code_a_i) - SUM_W'(win_q[ptr]);  // Add new, drop oldest
    end
  end

  // Output register
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_a_o <= '0;
    end else if (avg_en_i) begin
      dac_a_o <= ~sum_q[SUM_W-1 -: DAT_W];  // Mean, inverted
    end else begin
      dac_a_o <= code_a_i;                  // Same path as CH B
    end
  end

endmodule : dac_avg

// File: dac/dac_mix.sv
////////////////////////////////////////
// DAC mix, generator plus controller
// Saturate to DAT_W, format to DAC code
// CH B registered here, CH A to dac_avg
////////////////////////////////////////

`timescale 1ns/1ps

module dac_mix #(
  parameter int DAT_W = afe_pkg::DAT_W_DEF
) (
  input  logic                    adc_clk,
  input  logic                    adc_rstn,
  input  logic signed [DAT_W-1:0] gen_a_i,
  input  logic signed [DAT_W-1:0] gen_b_i,
  input  logic signed [DAT_W-1:0] ctl_a_i,
  input  logic signed [DAT_W-1:0] ctl_b_i,
  output logic signed [DAT_W-1:0] sat_a_o,   // To loopback
  output logic signed [DAT_W-1:0] sat_b_o,
  output logic [DAT_W-1:0]        code_a_o,  // Unregistered CH A code
  output logic [DAT_W-1:0]        dac_b_o
);

  localparam logic signed [DAT_W:0] SAT_MAX = (2**(DAT_W-1)) - 1;
  localparam logic signed [DAT_W:0] SAT_MIN = -(2**(DAT_W-1));

  logic signed [DAT_W:0] sum_a;  // One guard bit
  logic signed [DAT_W:0] sum_b;

  // Clamp on overflow of the guard bit
  function automatic logic [DAT_W-1:0] sat(input logic [DAT_W:0] s);
    if (s[DAT_W] ^ s[DAT_W-1]) begin
      return {s[DAT_W], {(DAT_W-1){~s[DAT_W]}}};
    end
    return s[DAT_W-1:0];
  endfunction

  // Two's complement to negative slope code
  function automatic logic [DAT_W-1:0] fmt(input logic [DAT_W-1:0] d);
    return {d[DAT_W-1], ~d[DAT_W-2:0]};
  endfunction

  assign sum_a = gen_a_i + ctl_a_i;
  assign sum_b = gen_b_i + ctl_b_i;

  assign sat_a_o  = sat(sum_a);
  assign sat_b_o  = sat(sum_b);
  assign code_a_o = fmt(sat_a_o);

  // CH B output register
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      dac_b_o <= '0;
    end else begin
      dac_b_o <= fmt(sat_b_o);
    end
  end

  // Saturated sample stays in range and equals the in-range sum
  a_sat_a: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    (sum_a > SAT_MAX) ? (sat_a_o == SAT_MAX) :
    ((sum_a < SAT_MIN) ? (sat_a_o == SAT_MIN) : (sat_a_o == sum_a)));
  a_sat_b: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    (sum_b > SAT_MAX) ? (sat_b_o == SAT_MAX) :
    ((sum_b < SAT_MIN) ? (sat_b_o == SAT_MIN) : (sat_b_o == sum_b)));

endmodule : dac_mix

// File: hdl/adc_front.sv
////////////////////////////////////////
// ADC capture and slope conversion
// Loopback swaps in the saturated DAC
// samples of the same cycle
////////////////////////////////////////

`timescale 1ns/1ps

module adc_front #(
  parameter int DAT_W = afe_pkg::DAT_W_DEF
) (
  input  logic                      adc_clk,
  input  logic                      adc_rstn,
  input  logic [afe_pkg::ADC_W-1:0] adc_dat_a_i,  // Raw, negative slope
  input  logic [afe_pkg::ADC_W-1:0] adc_dat_b_i,
  input  logic                      loop_en_i,
  input  logic signed [DAT_W-1:0]   loop_a_i,     // Saturated DAC sums
  input  logic signed [DAT_W-1:0]   loop_b_i,
  output logic signed [DAT_W-1:0]   adc_a_o,
  output logic signed [DAT_W-1:0]   adc_b_o
);
  import afe_pkg::*;

  logic [DAT_W-1:0] raw_a_q;  // Top bits of the ADC word
  logic [DAT_W-1:0] raw_b_q;
  logic [DAT_W-1:0] cnv_a;    // Two's complement
  logic [DAT_W-1:0] cnv_b;

  // Capture register, reserved LSBs dropped
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end else begin
      raw_a_q <= adc_dat_a_i[ADC_W-1 -: DAT_W];
      raw_b_q <= adc_dat_b_i[ADC_W-1 -: DAT_W];
    end
  end

  // Negative slope to two's complement
  assign cnv_a = {raw_a_q[DAT_W-1], ~raw_a_q[DAT_W-2:0]};
  assign cnv_b = {raw_b_q[DAT_W-1], ~raw_b_q[DAT_W-2:0]};

  // Loopback select, no register
  assign adc_a_o = loop_en_i ? loop_a_i : cnv_a;
  assign adc_b_o = loop_en_i ? loop_b_i : cnv_b;

endmodule : adc_front

// File: hdl/afe_regs.sv
////////////////////////////////////////
// APB register block, zero wait states
// 0x00 ID word, 0x04 control bits
// Other addresses answer with pslverr
////////////////////////////////////////

`timescale 1ns/1ps

module afe_regs (
  input  logic adc_clk,
  input  logic adc_rstn,
  apb_if.slave apb,
  output logic loop_en_o,  // Digital loopback
  output logic avg_en_o    // CH A averaging
);
  import afe_pkg::*;

  apb_state_e        state_q;
  logic              access;     // First access cycle after setup
  logic              addr_id;
  logic              addr_ctrl;
  logic              loop_q;
  logic              avg_q;
  logic [APB_DW-1:0] rdata;      // Read mux before qualification

  ////////////////////////////////////////
  // Phase tracking
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_SETUP: begin
          if (!apb.psel) begin
            state_q <= ST_IDLE;    // Master dropped the transfer
          end else if (apb.penable) begin
            state_q <= ST_ACCESS;  // Completed this cycle
          end
        end
        // Idle or just completed, back to back setup allowed
        default: state_q <= (apb.psel && !apb.penable) ? ST_SETUP : ST_IDLE;
      endcase
    end
  end

  assign access = (state_q == ST_SETUP) && apb.psel && apb.penable;

  // Address decode
  assign addr_id   = (apb.paddr == REG_ID_ADDR);
  assign addr_ctrl = (apb.paddr == REG_CTRL_ADDR);

  assign apb.pready  = access;                             // No wait state
  assign apb.pslverr = access && !(addr_id || addr_ctrl);

  ////////////////////////////////////////
  // Control register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      loop_q <= 1'b0;
      avg_q  <= 1'b0;
    end else if (access && apb.pwrite && addr_ctrl) begin
      loop_q <= apb.pwdata[CTRL_LOOP_BIT];
      avg_q  <= apb.pwdata[CTRL_AVG_BIT];
    end
  end

  assign loop_en_o = loop_q;
  assign avg_en_o  = avg_q;

  // Read data, unused bits zero
  always_comb begin
    rdata = '0;
    if (addr_id) begin
      rdata = AFE_ID;
    end else if (addr_ctrl) begin
      rdata[CTRL_LOOP_BIT] = loop_q;
      rdata[CTRL_AVG_BIT]  = avg_q;
    end
  end

  assign apb.prdata = (access && !apb.pwrite) ? rdata : '0;

  // Error only in an access cycle that follows its setup cycle
  a_slverr_access: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    apb.pslverr |-> (apb.psel && apb.penable && $past(apb.psel && !apb.penable)));

endmodule : afe_regs

// File: hdl/afe_top.sv
////////////////////////////////////////
// Analog front end top level
// ADC capture, DAC mix with channel A
// averaging and an APB control block
// Generator and controller samples come
// in as plain ports
////////////////////////////////////////

`timescale 1ns/1ps

module afe_top #(
  parameter int DAT_W    = afe_pkg::DAT_W_DEF,     // Sample width
  parameter int AVG_LOG2 = afe_pkg::AVG_LOG2_DEF   // Window depth, log2
) (
  input  logic                       adc_clk,
  input  logic                       adc_rstn,
  // ADC
  input  logic [afe_pkg::ADC_W-1:0]  adc_dat_a_i,  // Raw CH A
  input  logic [afe_pkg::ADC_W-1:0]  adc_dat_b_i,  // Raw CH B
  // Generator and controller samples
  input  logic signed [DAT_W-1:0]    gen_a_i,
  input  logic signed [DAT_W-1:0]    gen_b_i,
  input  logic signed [DAT_W-1:0]    ctl_a_i,
  input  logic signed [DAT_W-1:0]    ctl_b_i,
  // APB
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [afe_pkg::APB_AW-1:0] paddr_i,
  input  logic [afe_pkg::APB_DW-1:0] pwdata_i,
  output logic [afe_pkg::APB_DW-1:0] prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  // Samples out
  output logic signed [DAT_W-1:0]    adc_a_o,      // Two's complement
  output logic signed [DAT_W-1:0]    adc_b_o,
  output logic [DAT_W-1:0]           dac_a_o,      // Negative slope code
  output logic [DAT_W-1:0]           dac_b_o
);

  ////////////////////////////////////////
  // Local signals
  ////////////////////////////////////////

  apb_if apb ();

  logic                    loop_en;  // Digital loopback
  logic                    avg_en;   // CH A averaging
  logic signed [DAT_W-1:0] sat_a;    // Saturated sums
  logic signed [DAT_W-1:0] sat_b;
  logic [DAT_W-1:0]        code_a;   // CH A before averaging

  // APB request side from the pins
  assign apb.psel    = psel_i;
  assign apb.penable = penable_i;
  assign apb.pwrite  = pwrite_i;
  assign apb.paddr   = paddr_i;
  assign apb.pwdata  = pwdata_i;

  assign prdata_o  = apb.prdata;
  assign pready_o  = apb.pready;
  assign pslverr_o = apb.pslverr;

  ////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////

  afe_regs u_afe_regs (
    .adc_clk   (adc_clk),
    .adc_rstn  (adc_rstn),
    .apb       (apb.slave),
    .loop_en_o (loop_en),
    .avg_en_o  (avg_en)
  );

  adc_front #(.DAT_W(DAT_W)) u_adc_front (
    .adc_clk     (adc_clk),
    .adc_rstn    (adc_rstn),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (loop_en),
    .loop_a_i    (sat_a),  // Loopback from DAC path
    .loop_b_i    (sat_b),
    .adc_a_o     (adc_a_o),
    .adc_b_o     (adc_b_o)
  );

  dac_mix #(.DAT_W(DAT_W)) u_dac_mix (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .gen_a_i  (gen_a_i),
    .gen_b_i  (gen_b_i),
    .ctl_a_i  (ctl_a_i),
    .ctl_b_i  (ctl_b_i),
    .sat_a_o  (sat_a),
    .sat_b_o  (sat_b),
    .code_a_o (code_a),
    .dac_b_o  (dac_b_o)
  );

  dac_avg #(.DAT_W(DAT_W), .AVG_LOG2(AVG_LOG2)) u_dac_avg (
    .adc_clk  (adc_clk),
    .adc_rstn (adc_rstn),
    .avg_en_i (avg_en),
    .code_a_i (code_a),
    .dac_a_o  (dac_a_o)
  );

endmodule : afe_top

// File: testbench/tb_clk_gen.sv
////////////////////////////////////////
// Testbench clock and reset source
// 10 ns adc_clk, reset low for 2 edges
////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 2
) (
  output logic adc_clk_o,
  output logic adc_rstn_o
);

  initial begin
    adc_clk_o = 1'b0;
    forever #(PERIOD_NS / 2) adc_clk_o = ~adc_clk_o;
  end

  // Release on a rising edge, seen by the DUT from the next edge on
  initial begin
    adc_rstn_o = 1'b0;
    repeat (RST_CYCLES) @(posedge adc_clk_o);
    adc_rstn_o <= 1'b1;
  end

endmodule : tb_clk_gen

// File: testbench/tb_afe_top.sv
////////////////////////////////////////
// Testbench for the analog front end
// Random samples and APB traffic, checked
// every cycle against a reference model
////////////////////////////////////////

`timescale 1ns/1ps

module tb_afe_top;
  import afe_pkg::*;

  localparam int  DW        = DAT_W_DEF;
  localparam int  AL        = AVG_LOG2_DEF;
  localparam int  DEPTH     = 2**AL;               // Window length
  localparam int  SAT_HI    = 2**(DW-1) - 1;
  localparam int  SAT_LO    = -(2**(DW-1));
  localparam logic [DW-1:0] LOW_MASK = (1 << (DW-1)) - 1;  // Bits flipped by slope change
  localparam int  APB_WAIT  = 8;                   // Cycles allowed for pready
  localparam int  RST_WAIT  = 20;
  localparam time RUN_LIMIT = 50us;

  logic                    adc_clk;
  logic                    adc_rstn;
  logic [ADC_W-1:0]        adc_dat_a;
  logic [ADC_W-1:0]        adc_dat_b;
  logic signed [DW-1:0]    gen_a;
  logic signed [DW-1:0]    gen_b;
  logic signed [DW-1:0]    ctl_a;
  logic signed [DW-1:0]    ctl_b;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [APB_AW-1:0]       paddr;
  logic [APB_DW-1:0]       pwdata;
  logic [APB_DW-1:0]       prdata;
  logic                    pready;
  logic                    pslverr;
  logic signed [DW-1:0]    adc_a;
  logic signed [DW-1:0]    adc_b;
  logic [DW-1:0]           dac_a;
  logic [DW-1:0]           dac_b;

  ////////////////////////////////////////
  // Reference model state
  ////////////////////////////////////////

  logic [1:0]    ctrl_m;       // Shadow of the control bits
  int            win_m [DEPTH];
  int            sum_m;        // Window sum of formatted codes
  int            ptr_m;
  logic [DW-1:0] exp_dac_a;
  logic [DW-1:0] exp_dac_b;
  logic [DW-1:0] exp_adc_a;    // Registered ADC conversion
  logic [DW-1:0] exp_adc_b;

  tb_clk_gen #(.PERIOD_NS(10), .RST_CYCLES(2)) u_tb_clk_gen (
    .adc_clk_o  (adc_clk),
    .adc_rstn_o (adc_rstn)
  );

  afe_top #(.DAT_W(DW), .AVG_LOG2(AL)) u_afe_top (
    .adc_clk     (adc_clk),
    .adc_rstn    (adc_rstn),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .gen_a_i     (gen_a),
    .gen_b_i     (gen_b),
    .ctl_a_i     (ctl_a),
    .ctl_b_i     (ctl_b),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b)
  );

  // Negative slope <-> two's complement, top bit kept
  function automatic logic [DW-1:0] flip_slope(input logic [DW-1:0] d);
    return d ^ LOW_MASK;
  endfunction

  // Generator plus controller, clamped to the signed range
  function automatic logic [DW-1:0] sat_model(input logic signed [DW-1:0] g,
                                              input logic signed [DW-1:0] c);
    int s;
    s = int'(g) + int'(c);
    if (s > SAT_HI) begin
      s = SAT_HI;
    end else if (s < SAT_LO) begin
      s = SAT_LO;
    end
    return DW'(s);
  endfunction

  // Mostly random, one in four at a rail to force clamping
  function automatic logic [DW-1:0] rand_sample();
    int r;
    r = $urandom % 8;
    if (r == 0) return LOW_MASK;                 // Max positive
    if (r == 1) return ~LOW_MASK;                // Max negative
    return DW'($urandom);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // One clock edge of the model, inputs as seen at that edge
  task automatic model_step();
    logic [DW-1:0] code_a;
    code_a    = flip_slope(sat_model(gen_a, ctl_a));
    exp_dac_b = flip_slope(sat_model(gen_b, ctl_b));
    if (ctrl_m[CTRL_AVG_BIT]) begin
      exp_dac_a = ~DW'(sum_m >> AL);             // Window sum before this sample
    end else begin
      exp_dac_a = code_a;
    end
    sum_m        = sum_m + int'(code_a) - win_m[ptr_m];  // Oldest slot drops out
    win_m[ptr_m] = int'(code_a);
    ptr_m        = (ptr_m + 1) % DEPTH;
    exp_adc_a    = flip_slope(adc_dat_a[ADC_W-1 -: DW]);  // Reserved LSBs gone
    exp_adc_b    = flip_slope(adc_dat_b[ADC_W-1 -: DW]);
  endtask

  // Edge, then model and DAC outputs at +1 ns
  task automatic next_cycle();
    @(posedge adc_clk);
    #1;
    model_step();
    check_val("dac_a_o", dac_a, exp_dac_a);
    check_val("dac_b_o", dac_b, exp_dac_b);
  endtask

  ////////////////////////////////////////
  // APB master
  ////////////////////////////////////////

  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                          input logic [APB_DW-1:0] wdata,
                          output logic [APB_DW-1:0] rdata, output logic err);
    int n;
    psel    = 1'b1;                              // Setup
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    next_cycle();
    penable = 1'b1;                              // Access
    #1;
    n = 0;
    while (!pready && n < APB_WAIT) begin
      next_cycle();
      #1;
      n++;
    end
    assert (pready) else begin
      $display("APB transfer never saw pready");
      $display("Test failed");
      $fatal(1, "apb timeout");
    end
    rdata = prdata;
    err   = pslverr;
    next_cycle();                                // Completing edge
    if (wr && addr == REG_CTRL_ADDR) begin
      ctrl_m[0] = wdata[CTRL_LOOP_BIT];
      ctrl_m[1] = wdata[CTRL_AVG_BIT];
    end
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // Random samples, ADC outputs checked in both loopback modes
  task automatic run_samples(input int count);
    for (int i = 0; i < count; i++) begin
      next_cycle();
      if (!ctrl_m[CTRL_LOOP_BIT]) begin
        check_val("adc_a_o", $unsigned(adc_a), exp_adc_a);
        check_val("adc_b_o", $unsigned(adc_b), exp_adc_b);
      end
      adc_dat_a = ADC_W'($urandom);
      adc_dat_b = ADC_W'($urandom);
      gen_a     = rand_sample();
      gen_b     = rand_sample();
      ctl_a     = rand_sample();
      ctl_b     = rand_sample();
      #1;
      if (ctrl_m[CTRL_LOOP_BIT]) begin           // Same cycle sums
        check_val("adc_a_o", $unsigned(adc_a), sat_model(gen_a, ctl_a));
        check_val("adc_b_o", $unsigned(adc_b), sat_model(gen_b, ctl_b));
      end
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [APB_DW-1:0] rd;
    logic [APB_DW-1:0] wd;
    logic              err;
    int                n;
    void'($urandom(36));
    adc_dat_a = '0;
    adc_dat_b = '0;
    gen_a     = '0;
    gen_b     = '0;
    ctl_a     = '0;
    ctl_b     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    ctrl_m    = 2'b00;
    sum_m     = 0;
    ptr_m     = 0;
    exp_dac_a = '0;
    exp_dac_b = '0;
    exp_adc_a = '0;
    exp_adc_b = '0;
    for (int i = 0; i < DEPTH; i++) begin
      win_m[i] = 0;
    end
    n = 0;
    do begin
      @(posedge adc_clk);
      #1;
      n++;
    end while (!adc_rstn && n < RST_WAIT);
    assert (adc_rstn) else begin
      $display("Reset was never released");
      $display("Test failed");
      $fatal(1, "reset timeout");
    end

    // Register map
    apb_xfer(1'b0, REG_ID_ADDR, '0, rd, err);
    check_val("prdata_o", rd, AFE_ID);
    check_val("pslverr_o", 32'(err), 32'h0);
    repeat (6) begin
      wd = $urandom;
      apb_xfer(1'b1, REG_CTRL_ADDR, wd, rd, err);
      check_val("pslverr_o", 32'(err), 32'h0);
      apb_xfer(1'b0, REG_CTRL_ADDR, '0, rd, err);
      check_val("prdata_o", rd, {30'b0, wd[CTRL_AVG_BIT], wd[CTRL_LOOP_BIT]});
    end
    apb_xfer(1'b0, 8'h08, '0, rd, err);          // Unmapped
    check_val("pslverr_o", 32'(err), 32'h1);
    check_val("prdata_o", rd, 32'h0);
    apb_xfer(1'b1, 8'h08, $urandom, rd, err);
    check_val("pslverr_o", 32'(err), 32'h1);
    apb_xfer(1'b1, REG_ID_ADDR, $urandom, rd, err);  // Ignored, no error
    check_val("pslverr_o", 32'(err), 32'h0);
    apb_xfer(1'b0, REG_ID_ADDR, '0, rd, err);
    check_val("prdata_o", rd, AFE_ID);

    // Conversion and plain DAC path
    apb_xfer(1'b1, REG_CTRL_ADDR, 32'h0, rd, err);
    run_samples(200);
    // Loopback
    apb_xfer(1'b1, REG_CTRL_ADDR, 32'h1, rd, err);
    run_samples(100);
    // Averaging, well past one window
    apb_xfer(1'b1, REG_CTRL_ADDR, 32'h2, rd, err);
    run_samples(300);
    // Both on
    apb_xfer(1'b1, REG_CTRL_ADDR, 32'h3, rd, err);
    run_samples(100);
    apb_xfer(1'b0, REG_CTRL_ADDR, '0, rd, err);
    check_val("prdata_o", rd, 32'h3);

    $display("Test passed");
    $finish;
  end

  // Run limit
  initial begin
    #(RUN_LIMIT);
    $display("Simulation ran past its time limit");
    $display("Test failed");
    $fatal(1, "global timeout");
  end

endmodule : tb_afe_top

// File: filelist.f
common/afe_pkg.sv
common/apb_if.sv
dac/avg_window_ptr.sv
dac/dac_avg.sv
dac/dac_mix.sv
hdl/adc_front.sv
hdl/afe_regs.sv
hdl/afe_top.sv
testbench/tb_clk_gen.sv
testbench/tb_afe_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_afe_top -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build error"
  exit 1
fi

./obj_dir/Vtb_afe_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
  echo "No result line in $LOG"
  exit 1
fi
exit 0
